/* design/kitchen_pkg.sv */
`default_nettype none

package kitchen_pkg;

   ////////////////////////////////////////
   // widths with a meaning
   ////////////////////////////////////////
   typedef logic [1:0] player_id_t;     // player index
   typedef logic [1:0] player_count_t;  // active players minus one
   typedef logic [8:0] coord_t;         // one board coordinate
   typedef logic [7:0] time_left_t;     // seconds left in the round

   // shared by host and link, so the encoding is fixed
   typedef enum logic [2:0] {
      WELCOME = 3'd0,
      START   = 3'd1,
      PLAY    = 3'd2,
      PAUSE   = 3'd3,
      FINISH  = 3'd4
   } game_state_e;

   ////////////////////////////////////////
   // bundles
   ////////////////////////////////////////
   typedef struct packed {
      coord_t x;
      coord_t y;
   } position_t;

   typedef position_t [3:0] player_positions_t;  // indexed by player

   typedef struct packed {
      position_t peer_a;  // lowest index peer
      position_t peer_b;
      position_t peer_c;
   } peer_set_t;

   typedef struct packed {
      logic left;
      logic right;
      logic up;
      logic down;
      logic chop;
   } buttons_t;

   typedef struct packed {
      logic [6:0] cathodes;  // g down to a, active low
      logic [7:0] anodes;    // active low
   } seg_drive_t;

   ////////////////////////////////////////
   // constants
   ////////////////////////////////////////
   localparam time_left_t ROUND_SECONDS = 8'd180;
   localparam player_id_t HOST_ID = 2'd0;  // owns the game state
   localparam int DIGITS = 8;
   localparam int DEFAULT_SETTLE_CYCLES = 1_000_000;
   localparam int DEFAULT_SCAN_CYCLES = 100_000;
   localparam int DEFAULT_FRAMES_PER_SECOND = 60;

endpackage

`default_nettype wire

/* design/button_debounce.sv */
`timescale 1ns/1ns
`default_nettype none

module button_debounce #(
   parameter int settle_cycles = kitchen_pkg::DEFAULT_SETTLE_CYCLES
) (
   input  logic                  clk_in,
   input  logic                  reset_in,
   input  kitchen_pkg::buttons_t raw_buttons,
   output kitchen_pkg::buttons_t buttons
);

   localparam int NUM_BUTTONS = $bits(kitchen_pkg::buttons_t);
   localparam int CNT_W = $clog2(settle_cycles + 2);

   logic [NUM_BUTTONS-1:0] raw_bits;
   logic [NUM_BUTTONS-1:0] sample;  // last raw value seen per button
   logic [NUM_BUTTONS-1:0] clean;
   logic [CNT_W-1:0]       settle_cnt [NUM_BUTTONS];

   assign raw_bits = raw_buttons;
   assign buttons  = clean;

   // any change restarts the count, a full count copies the sample out
   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         sample <= raw_bits;
         clean  <= raw_bits;  // start out matching the pins
         for (int i = 0; i < NUM_BUTTONS; i++) begin
            settle_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_BUTTONS; i++) begin
            if (raw_bits[i] != sample[i]) begin
               sample[i]     <= raw_bits[i];
               settle_cnt[i] <= '0;
            end else if (settle_cnt[i] == CNT_W'(settle_cycles)) begin
               clean[i] <= sample[i];  // held long enough
            end else begin
               settle_cnt[i] <= settle_cnt[i] + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* design/peer_select.sv */
`timescale 1ns/1ns
`default_nettype none

module peer_select (
   input  logic                           clk_in,
   input  logic                           reset_in,
   input  kitchen_pkg::player_id_t        local_id,
   input  kitchen_pkg::player_count_t     player_count,
   input  kitchen_pkg::player_positions_t positions,
   output kitchen_pkg::peer_set_t         peers
);

   kitchen_pkg::position_t [2:0] slots;  // compacted peers, slot 0 first
   logic [1:0]                   peer_count;
   logic [2:0]                   active_peers;  // counted from the inputs alone
   logic [2:0]                   slot_free;  // bit k set when slot k has no peer

   ////////////////////////////////////////
   // compaction
   ////////////////////////////////////////
   always_comb begin
      slots      = '0;
      peer_count = 2'd0;
      for (int i = 0; i < 4; i++) begin
         // active and not ourselves
         if (kitchen_pkg::player_id_t'(i) <= player_count &&
             kitchen_pkg::player_id_t'(i) != local_id) begin
            if (peer_count != 2'd3) begin
               slots[peer_count] = positions[i];
               peer_count        = peer_count + 2'd1;
            end
         end
      end
   end

   // active players minus ourselves when we are one of them
   assign active_peers = 3'(player_count) + 3'd1 - {2'b00, local_id <= player_count};

   always_comb begin
      for (int k = 0; k < 3; k++) begin
         slot_free[k] = (k >= int'(active_peers));
      end
   end

   ////////////////////////////////////////
   // output register
   ////////////////////////////////////////
   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         peers <= '0;
      end else begin
         peers.peer_a <= slots[0];
         peers.peer_b <= slots[1];
         peers.peer_c <= slots[2];
      end
   end

   // empty slots must read as zero one cycle on
   a_unused_slots_zero : assert property (
      @(posedge clk_in) disable iff (reset_in)
      1'b1 |=> (($past(slot_free) &
                 {|peers.peer_c, |peers.peer_b, |peers.peer_a}) == 3'b000)
   );

endmodule

`default_nettype wire

/* design/round_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module round_timer #(
   parameter int frames_per_second = kitchen_pkg::DEFAULT_FRAMES_PER_SECOND
) (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  kitchen_pkg::player_id_t  local_id,
   input  kitchen_pkg::game_state_e host_state,
   input  kitchen_pkg::game_state_e remote_state,
   input  logic                     frame_tick,
   output kitchen_pkg::game_state_e effective_state,
   output kitchen_pkg::time_left_t  time_left,
   output logic                     timer_run
);

   localparam int PRESC_W = $clog2(frames_per_second + 1);

   logic               reload;
   logic [PRESC_W-1:0] frame_cnt;  // frame ticks into the current second

   // host owns the state, everyone else follows the link
   assign effective_state = (local_id == kitchen_pkg::HOST_ID) ? host_state : remote_state;

   always_comb begin
      timer_run = 1'b0;
      reload    = 1'b0;
      case (effective_state)
         kitchen_pkg::PLAY:    timer_run = 1'b1;
         kitchen_pkg::WELCOME,
         kitchen_pkg::START:   reload = 1'b1;
         default:              ;  // pause and finish hold
      endcase
   end

   ////////////////////////////////////////
   // seconds countdown
   ////////////////////////////////////////
   always_ff @(posedge clk_in) begin
      if (reset_in || reload) begin
         time_left <= kitchen_pkg::ROUND_SECONDS;
         frame_cnt <= '0;
      end else if (timer_run && frame_tick) begin
         if (frame_cnt == PRESC_W'(frames_per_second - 1)) begin
            frame_cnt <= '0;
            if (time_left != '0) begin
               time_left <= time_left - 1'b1;  // stops at zero
            end
         end else begin
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

   a_no_rise_without_reload : assert property (
      @(posedge clk_in) disable iff (reset_in)
      !reload |=> (time_left <= $past(time_left))
   );

endmodule

`default_nettype wire

/* design/status_display.sv */
`timescale 1ns/1ns
`default_nettype none

module status_display #(
   parameter int scan_cycles = kitchen_pkg::DEFAULT_SCAN_CYCLES
) (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  kitchen_pkg::game_state_e effective_state,
   input  kitchen_pkg::time_left_t  time_left,
   output kitchen_pkg::seg_drive_t  seg
);

   localparam int DWELL_W = $clog2(scan_cycles + 2);

   logic [kitchen_pkg::DIGITS-1:0][3:0] word;
   logic [kitchen_pkg::DIGITS-1:0]      digit_sel;  // one-hot, bit 0 is the rightmost digit
   logic [DWELL_W-1:0]                  dwell_cnt;
   logic [3:0]                          shown_digit;

   // lit segments for a hex value, g down to a
   function automatic logic [6:0] hex_segments(input logic [3:0] value);
      logic [6:0] lit;
      case (value)
         4'h0:    lit = 7'b011_1111;
         4'h1:    lit = 7'b000_0110;
         4'h2:    lit = 7'b101_1011;
         4'h3:    lit = 7'b100_1111;
         4'h4:    lit = 7'b110_0110;
         4'h5:    lit = 7'b110_1101;
         4'h6:    lit = 7'b111_1101;
         4'h7:    lit = 7'b000_0111;
         4'h8:    lit = 7'b111_1111;
         4'h9:    lit = 7'b110_1111;
         4'ha:    lit = 7'b111_0111;
         4'hb:    lit = 7'b111_1100;
         4'hc:    lit = 7'b011_1001;
         4'hd:    lit = 7'b101_1110;
         4'he:    lit = 7'b111_1001;
         default: lit = 7'b111_0001;  // f
      endcase
      return lit;
   endfunction

   ////////////////////////////////////////
   // display word
   ////////////////////////////////////////
   always_comb begin
      word                          = '0;  // middle digits stay blank zeros
      word[kitchen_pkg::DIGITS-1]   = {1'b0, effective_state};
      word[1]                       = time_left[7:4];
      word[0]                       = time_left[3:0];
   end

   always_comb begin
      shown_digit = word[0];
      for (int k = 1; k < kitchen_pkg::DIGITS; k++) begin
         if (digit_sel[k]) shown_digit = word[k];
      end
   end

   ////////////////////////////////////////
   // scan and segment register
   ////////////////////////////////////////
   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         digit_sel    <= kitchen_pkg::DIGITS'(1);
         dwell_cnt    <= '0;
         seg.anodes   <= ~kitchen_pkg::DIGITS'(1);
         seg.cathodes <= ~hex_segments(word[0]);
      end else begin
         if (dwell_cnt == DWELL_W'(scan_cycles)) begin
            dwell_cnt <= '0;
            digit_sel <= {digit_sel[kitchen_pkg::DIGITS-2:0], digit_sel[kitchen_pkg::DIGITS-1]};
         end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
         end
         seg.anodes   <= ~digit_sel;  // lags the select by one cycle
         seg.cathodes <= ~hex_segments(shown_digit);
      end
   end

   a_one_anode_low : assert property (
      @(posedge clk_in) disable iff (reset_in)
      $onehot(~seg.anodes)
   );

endmodule

`default_nettype wire

/* design/kitchen_front_end.sv */
`timescale 1ns/1ns
`default_nettype none

module kitchen_front_end #(
   parameter int settle_cycles     = kitchen_pkg::DEFAULT_SETTLE_CYCLES,
   parameter int scan_cycles       = kitchen_pkg::DEFAULT_SCAN_CYCLES,
   parameter int frames_per_second = kitchen_pkg::DEFAULT_FRAMES_PER_SECOND
) (
   input  logic                           clk_in,
   input  logic                           reset_in,
   input  kitchen_pkg::buttons_t          raw_buttons,   // straight from the pins
   input  kitchen_pkg::player_id_t        local_id,
   input  kitchen_pkg::player_count_t     player_count,
   input  kitchen_pkg::player_positions_t positions,
   input  kitchen_pkg::game_state_e       host_state,
   input  kitchen_pkg::game_state_e       remote_state,
   input  logic                           frame_tick,    // one pulse per frame
   output kitchen_pkg::buttons_t          buttons,
   output kitchen_pkg::peer_set_t         peers,
   output kitchen_pkg::time_left_t        time_left,
   output logic                           timer_run,
   output kitchen_pkg::seg_drive_t        seg
);

   kitchen_pkg::game_state_e effective_state;  // timer stage to display stage

   ////////////////////////////////////////
   // side stages
   ////////////////////////////////////////
   button_debounce #(.settle_cycles(settle_cycles)) u_button_debounce (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .raw_buttons (raw_buttons),
      .buttons     (buttons)
   );

   peer_select u_peer_select (
      .clk_in       (clk_in),
      .reset_in     (reset_in),
      .local_id     (local_id),
      .player_count (player_count),
      .positions    (positions),
      .peers        (peers)
   );

   ////////////////////////////////////////
   // status path
   ////////////////////////////////////////
   round_timer #(.frames_per_second(frames_per_second)) u_round_timer (
      .clk_in          (clk_in),
      .reset_in        (reset_in),
      .local_id        (local_id),
      .host_state      (host_state),
      .remote_state    (remote_state),
      .frame_tick      (frame_tick),
      .effective_state (effective_state),
      .time_left       (time_left),
      .timer_run       (timer_run)
   );

   status_display #(.scan_cycles(scan_cycles)) u_status_display (
      .clk_in          (clk_in),
      .reset_in        (reset_in),
      .effective_state (effective_state),
      .time_left       (time_left),
      .seg             (seg)
   );

endmodule

`default_nettype wire

/* verification/kitchen_front_end_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module kitchen_front_end_tb;

   localparam int SETTLE = 8;
   localparam int SCAN = 3;
   localparam int FPS = 2;
   localparam int MAX_CYCLES = 6000;  // about twice the ~2500 cycles of stimulus

   logic                           clk_in;
   logic                           reset_in;
   kitchen_pkg::buttons_t          raw_buttons;
   kitchen_pkg::player_id_t        local_id;
   kitchen_pkg::player_count_t     player_count;
   kitchen_pkg::player_positions_t positions;
   kitchen_pkg::game_state_e       host_state;
   kitchen_pkg::game_state_e       remote_state;
   logic                           frame_tick;
   kitchen_pkg::buttons_t          buttons;
   kitchen_pkg::peer_set_t         peers;
   kitchen_pkg::time_left_t        time_left;
   logic                           timer_run;
   kitchen_pkg::seg_drive_t        seg;

   integer seed = 69799;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;
   int     steps = 0;  // anode advances seen

   // reference state, updated on the falling edge
   kitchen_pkg::time_left_t        exp_time = kitchen_pkg::ROUND_SECONDS;
   int                             presc = 0;
   kitchen_pkg::buttons_t          exp_buttons;
   logic                           btn_check;  // off while a held change settles
   kitchen_pkg::player_id_t        last_id;
   kitchen_pkg::player_count_t     last_count;
   kitchen_pkg::player_positions_t last_pos;
   logic                           was_reset = 1'b1;
   logic [31:0]                    last_word;
   logic [7:0]                     last_anodes;

   kitchen_front_end #(
      .settle_cycles     (SETTLE),
      .scan_cycles       (SCAN),
      .frames_per_second (FPS)
   ) u_dut (
      .clk_in       (clk_in),
      .reset_in     (reset_in),
      .raw_buttons  (raw_buttons),
      .local_id     (local_id),
      .player_count (player_count),
      .positions    (positions),
      .host_state   (host_state),
      .remote_state (remote_state),
      .frame_tick   (frame_tick),
      .buttons      (buttons),
      .peers        (peers),
      .time_left    (time_left),
      .timer_run    (timer_run),
      .seg          (seg)
   );

   initial begin
      clk_in = 1'b0;
      forever #2 clk_in = ~clk_in;
   end

   ////////////////////////////////////////
   // reference functions
   ////////////////////////////////////////
   function automatic kitchen_pkg::peer_set_t expected_peers(
      input kitchen_pkg::player_id_t        id,
      input kitchen_pkg::player_count_t     count,
      input kitchen_pkg::player_positions_t pos
   );
      kitchen_pkg::position_t found [3];
      int                     n;
      n = 0;
      for (int i = 0; i < 3; i++) begin
         found[i] = '0;
      end
      for (int p = 0; p < 4; p++) begin
         if (p <= int'(count) && p != int'(id)) begin  // active and not local
            found[n] = pos[p];
            n++;
         end
      end
      return {found[0], found[1], found[2]};
   endfunction

   // active low, a in bit 0
   function automatic logic [6:0] hex_cathodes(input logic [3:0] value);
      logic [6:0] lit;
      case (value)
         4'h0: lit = 7'h3f;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5b;
         4'h3: lit = 7'h4f;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6d;
         4'h6: lit = 7'h7d;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7f;
         4'h9: lit = 7'h6f;
         4'ha: lit = 7'h77;
         4'hb: lit = 7'h7c;
         4'hc: lit = 7'h39;
         4'hd: lit = 7'h5e;
         4'he: lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return ~lit;
   endfunction

   function automatic logic [31:0] expected_word(
      input kitchen_pkg::game_state_e st,
      input kitchen_pkg::time_left_t  t
   );
      return {1'b0, st, 20'h0, t};  // state, five zero digits, seconds
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
      end
   endtask

   ////////////////////////////////////////
   // comparison on the falling edge
   ////////////////////////////////////////
   always @(negedge clk_in) begin
      kitchen_pkg::game_state_e eff;
      kitchen_pkg::peer_set_t   exp_peers;
      eff = (local_id == kitchen_pkg::HOST_ID) ? host_state : remote_state;
      if (!reset_in) begin
         check_value("time_left", exp_time, time_left);
         check_value("timer_run", eff == kitchen_pkg::PLAY, timer_run);
         exp_peers = '0;
         if (!was_reset) exp_peers = expected_peers(last_id, last_count, last_pos);
         check_value("peers", exp_peers, peers);
         if (btn_check) check_value("buttons", exp_buttons, buttons);
         check_value("one anode low", 1'b1, $onehot(~seg.anodes));
         for (int k = 0; k < 8; k++) begin
            if (!seg.anodes[k]) check_value("cathodes", hex_cathodes(last_word[4*k +: 4]),
                                            seg.cathodes);
         end
         if (was_reset) begin
            check_value("anodes after reset", 8'hfe, seg.anodes);
         end else if (seg.anodes != last_anodes) begin
            check_value("anode order", {last_anodes[6:0], last_anodes[7]}, seg.anodes);
            steps++;
         end
      end
      if (reset_in) begin
         exp_time = kitchen_pkg::ROUND_SECONDS;
         presc    = 0;
      end
      last_word = expected_word(eff, exp_time);  // shown one cycle on
      if (!reset_in) begin
         if (eff == kitchen_pkg::WELCOME || eff == kitchen_pkg::START) begin
            exp_time = kitchen_pkg::ROUND_SECONDS;
            presc    = 0;
         end else if (eff == kitchen_pkg::PLAY && frame_tick) begin
            presc++;
            if (presc == FPS) begin  // one second of frames
               presc = 0;
               if (exp_time != 0) exp_time = exp_time - 8'd1;
            end
         end
      end
      last_id     = local_id;
      last_count  = player_count;
      last_pos    = positions;
      last_anodes = seg.anodes;
      was_reset   = reset_in;
   end

   always @(posedge clk_in) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: stimulus still running after %0d cycles", MAX_CYCLES);
         $display("checks %0d, errors %0d", checks, errors);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   task automatic drive_state(input kitchen_pkg::player_id_t id,
                              input kitchen_pkg::game_state_e st, input int n);
      kitchen_pkg::game_state_e other;
      logic [31:0]              r;
      // the unused source disagrees, so a wrong select shows up
      other = (st == kitchen_pkg::PLAY) ? kitchen_pkg::PAUSE : kitchen_pkg::PLAY;
      repeat (n) begin
         @(posedge clk_in);
         r = $random(seed);
         local_id     <= id;
         host_state   <= (id == kitchen_pkg::HOST_ID) ? st : other;
         remote_state <= (id == kitchen_pkg::HOST_ID) ? other : st;
         frame_tick   <= r[0];
      end
   endtask

   task automatic run_round(input kitchen_pkg::player_id_t id);
      drive_state(id, kitchen_pkg::START, 4);
      drive_state(id, kitchen_pkg::PLAY, 60);
      drive_state(id, kitchen_pkg::PAUSE, 30);
      drive_state(id, kitchen_pkg::PLAY, 40);
      drive_state(id, kitchen_pkg::START, 5);
      drive_state(id, kitchen_pkg::PLAY, 850);  // long enough to reach zero
      drive_state(id, kitchen_pkg::FINISH, 20);
      drive_state(id, kitchen_pkg::WELCOME, 4);
   endtask

   initial begin
      logic [31:0] r;
      int          b;
      int          len;
      reset_in     = 1'b1;
      raw_buttons  = '0;
      local_id     = '0;
      player_count = 2'd3;  // peers would be nonzero without the reset
      positions    = '1;
      host_state   = kitchen_pkg::PAUSE;  // holds, so only the reset loads the timer
      remote_state = kitchen_pkg::WELCOME;
      frame_tick   = 1'b0;
      exp_buttons  = '0;
      btn_check    = 1'b1;
      repeat (2) @(posedge clk_in);
      reset_in   <= 1'b0;
      host_state <= kitchen_pkg::WELCOME;

      // every id and count with random positions
      for (int id = 0; id < 4; id++) begin
         for (int cnt = 0; cnt < 4; cnt++) begin
            repeat (6) begin
               @(posedge clk_in);
               local_id     <= kitchen_pkg::player_id_t'(id);
               player_count <= kitchen_pkg::player_count_t'(cnt);
               for (int i = 0; i < 4; i++) begin
                  r = $random(seed);
                  positions[i] <= r[17:0];
               end
            end
         end
      end

      // short glitches must stay invisible
      for (int n = 0; n < 16; n++) begin
         r   = $random(seed);
         b   = int'(r[7:0] % 8'd5);
         len = 1 + int'(r[15:8] % 8'd7);
         @(posedge clk_in);
         raw_buttons <= raw_buttons ^ (5'b1 << b);
         repeat (len) @(posedge clk_in);
         raw_buttons <= raw_buttons ^ (5'b1 << b);
         repeat (12) @(posedge clk_in);
      end
      for (int i = 0; i < 5; i++) begin
         @(posedge clk_in);
         raw_buttons <= raw_buttons ^ (5'b1 << i);
         btn_check = 1'b0;
         repeat (11) @(posedge clk_in);
         exp_buttons = raw_buttons;  // must have arrived by now
         btn_check   = 1'b1;
      end

      player_count <= 2'd3;
      run_round(2'd0);  // host state
      run_round(2'd2);  // link state

      @(posedge clk_in);
      check_value("anode steps", 1'b1, steps >= 8);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
design/kitchen_pkg.sv
design/button_debounce.sv
design/peer_select.sv
design/round_timer.sv
design/status_display.sv
design/kitchen_front_end.sv
verification/kitchen_front_end_tb.sv

/* Makefile */
# Verilator run of the kitchen front end testbench

VERILATOR ?= verilator
TOP       ?= kitchen_front_end_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass or fail is read from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
